// ==== verif/program_patterns.txt ====
// @000 program words, @03f record count, @040 data doublewords
// @080 records of four words: {wen,rd[4:0]} rd_data next_pc mem_addr
@000
FFB00093 00300113 402081B3 0020A233 0020B2B3 4010D313 01F1139B 4023D43B
00103823 01000483 01005503 01802583 01806603 01003683 0020C463 00100A13
0020E463 00029463 0020F463 00100A13 0080076F 00100A13 00000797 00D78867
00100A13 800008B7 0011D463 00168463
@03f
18
@040
0000000000000000 0000000000000000 0000000000000000 0123456789ABCDEF
@080
21 FFFFFFFFFFFFFFFB 04 00
22 0000000000000003 08 00
23 FFFFFFFFFFFFFFF8 0C 00
24 0000000000000001 10 00
25 0000000000000000 14 00
26 FFFFFFFFFFFFFFFD 18 00
27 FFFFFFFF80000000 1C 00
28 FFFFFFFFF0000000 20 00
00 0000000000000000 24 10
29 FFFFFFFFFFFFFFFB 28 10
2A 000000000000FFFB 2C 10
2B FFFFFFFF89ABCDEF 30 18
2C 0000000089ABCDEF 34 18
2D FFFFFFFFFFFFFFFB 38 10
00 0000000000000000 40 00
00 0000000000000000 44 00
00 0000000000000000 48 00
00 0000000000000000 50 00
2E 0000000000000054 58 00
2F 0000000000000058 5C 00
30 0000000000000060 64 00
31 FFFFFFFF80000000 68 00
00 0000000000000000 6C 00
00 0000000000000000 74 00

// ==== rv_core.f ====
source/rv_pkg.sv
source/alu.sv
source/exu.sv
source/regfile.sv
source/idu.sv
source/perf_counter.sv
source/core_ctrl.sv
source/rv_core.sv
verif/rv_core_assertions.sv
verif/tb_rv_core.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -Mdir obj_dir

run: compile
	./obj_dir/Vtb_rv_core > sim.log; cat sim.log
	@if grep -q "\*\* FAIL \*\*" sim.log; then exit 1; fi
	@grep -q "\*\* PASS \*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_rv_core.sv ====
// RV64I core testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

	localparam int REC_BASE = 128; // first expected retire record
	localparam int DAT_BASE = 64;  // initial data doublewords

	logic        clk;
	logic        i_rst;
	logic [63:0] o_imem_addr;
	logic [31:0] i_imem_rdata;
	logic        o_dmem_r, o_dmem_w;
	logic [63:0] o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
	logic        o_retire, o_retire_wen;
	logic [4:0]  o_retire_rd;
	logic [63:0] o_retire_data, o_retire_pc;
	logic [31:0] o_cycle, o_instret;

	logic [63:0] pat [256];
	logic [63:0] dmem [16];
	logic [31:0] imem_q;
	logic [63:0] dmem_q;
	int          n_tests = 0;
	int          retired = 0;
	int          errors = 0;
	int          passed = 0;
	int          cum_cycles = 0;
	logic [63:0] cur_pc = '0;

	rv_core #(.XLEN(64), .CNT_W(32)) dut (.*);

	task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// both memories sampled mid-cycle, answered one cycle later
	always @(negedge clk) begin
		imem_q <= pat[o_imem_addr[7:2]][31:0];
		if (o_dmem_w)
			dmem[o_dmem_addr[6:3]] <= o_dmem_wdata; // whole doubleword
		if (o_dmem_r)
			dmem_q <= dmem[o_dmem_addr[6:3]];
	end

	always @(posedge clk) begin
		#5;
		i_imem_rdata <= imem_q;
		i_dmem_rdata <= dmem_q;
	end

	// address of the pending load or store
	always @(negedge clk) begin
		if (!i_rst && (o_dmem_r || o_dmem_w) && retired < n_tests)
			compare("dmem addr", o_dmem_addr, pat[REC_BASE + 4*retired + 3]);
	end

	always @(negedge clk) begin
		int          b;
		int          err_before;
		int          len;
		logic [63:0] rec;
		if (!i_rst && o_retire && retired < n_tests) begin
			b          = REC_BASE + 4*retired;
			rec        = pat[b];
			err_before = errors;
			len        = (pat[b+3] != 0) ? 5 : 4; // loads and stores take MEM
			compare("retire wen", 64'(o_retire_wen), 64'(rec[5]));
			if (rec[5]) begin
				compare("retire rd", 64'(o_retire_rd), 64'(rec[4:0]));
				compare("retire data", o_retire_data, pat[b+1]);
			end
			compare("next pc", o_retire_pc, pat[b+2]);
			compare("cycle count", 64'(o_cycle), 64'(cum_cycles + len - 1));
			compare("instret", 64'(o_instret), 64'(retired));
			cum_cycles += len;
			if (errors == err_before) begin
				passed++;
				$display("test %0d, instruction at pc %h: ok", retired + 1, cur_pc);
			end else
				$display("test %0d, instruction at pc %h: failed", retired + 1, cur_pc);
			cur_pc = pat[b+2];
			retired++;
		end
	end

	// run limit from the number of records
	initial begin
		int limit;
		int cyc;
		cyc = 0;
		wait (n_tests != 0);
		limit = 5*n_tests + 50;
		while (cyc < limit) begin
			@(posedge clk);
			cyc++;
		end
		$display("timeout after %0d cycles, %0d of %0d instructions retired",
			cyc, retired, n_tests);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		i_rst        = 1'b1;
		i_imem_rdata = '0;
		i_dmem_rdata = '0;
		imem_q       = '0;
		dmem_q       = '0;
		for (int i = 0; i < 256; i++)
			pat[i] = '0;
		$readmemh("verif/program_patterns.txt", pat);
		for (int i = 0; i < 16; i++)
			dmem[i] = pat[DAT_BASE + i];
		repeat (10) @(posedge clk);
		#5 i_rst = 1'b0;
		n_tests = int'(pat[63]);
		@(negedge clk); // first fetch cycle
		begin
			int err_before;
			err_before = errors;
			compare("dmem_r after reset", 64'(o_dmem_r), 64'd0);
			compare("dmem_w after reset", 64'(o_dmem_w), 64'd0);
			compare("retire after reset", 64'(o_retire), 64'd0);
			compare("cycle after reset", 64'(o_cycle), 64'd0);
			compare("instret after reset", 64'(o_instret), 64'd0);
			$display("reset test: %s", (errors == err_before) ? "ok" : "failed");
		end
		wait (retired == n_tests);
		@(negedge clk);
		$display("%0d instructions checked, %0d ok, %0d mismatches", n_tests, passed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/rv_core_assertions.sv ====
// Core strobe assertions
`timescale 1ns/1ns
`default_nettype none

module rv_core_assertions (
	input logic clk,
	input logic i_rst,
	input logic o_dmem_r,
	input logic o_dmem_w,
	input logic o_retire
);

	// one memory access at a time
	a_rw_excl: assert property (@(posedge clk) disable iff (i_rst) !(o_dmem_r && o_dmem_w))
		else $error("dmem read and write strobes high together");

	a_retire_pulse: assert property (@(posedge clk) disable iff (i_rst) o_retire |=> !o_retire)
		else $error("retire strobe high in two consecutive cycles");

	a_reset_quiet: assert property (@(posedge clk)
		(i_rst && $past(i_rst)) |-> !(o_dmem_r || o_dmem_w || o_retire))
		else $error("strobe active during reset");

endmodule

bind core_ctrl rv_core_assertions u_assert (.*);

`default_nettype wire

// ==== source/rv_core.sv ====
// RV64I multi-cycle core
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_pkg::*; #(
	parameter int XLEN  = XLEN_DEF,
	parameter int CNT_W = CNT_W_DEF
) (
	input  logic             clk,
	input  logic             i_rst,
	output logic [XLEN-1:0]  o_imem_addr,
	input  logic [31:0]      i_imem_rdata,
	output logic             o_dmem_r,
	output logic             o_dmem_w,
	output logic [XLEN-1:0]  o_dmem_addr,
	output logic [XLEN-1:0]  o_dmem_wdata,
	input  logic [XLEN-1:0]  i_dmem_rdata,
	output logic             o_retire,
	output logic             o_retire_wen,
	output logic [4:0]       o_retire_rd,
	output logic [XLEN-1:0]  o_retire_data,
	output logic [XLEN-1:0]  o_retire_pc,
	output logic [CNT_W-1:0] o_cycle,
	output logic [CNT_W-1:0] o_instret
);
	logic [31:0]     inst;
	logic [XLEN-1:0] pc;
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic            inst30;
	logic [4:0]      rs1, rs2, rd;
	logic [XLEN-1:0] imm, src1, src2;
	logic            rd_wen, reg_we, mem_r, mem_w;
	logic [XLEN-1:0] rd_data, dnpc;

	// retire record comes straight from the current instruction
	assign o_retire_wen  = reg_we;
	assign o_retire_rd   = rd;
	assign o_retire_data = rd_data;
	assign o_retire_pc   = dnpc;

	core_ctrl #(.XLEN(XLEN)) u_ctrl (
		.clk(clk), .i_rst(i_rst),
		.i_imem_rdata(i_imem_rdata), .i_mem_r(mem_r), .i_mem_w(mem_w),
		.i_rd_wen(rd_wen), .i_dnpc(dnpc),
		.o_imem_addr(o_imem_addr), .o_inst(inst), .o_pc(pc),
		.o_dmem_r(o_dmem_r), .o_dmem_w(o_dmem_w),
		.o_reg_we(reg_we), .o_retire(o_retire)
	);

	perf_counter #(.CNT_W(CNT_W)) u_perf (
		.clk(clk), .i_rst(i_rst), .i_retire(o_retire),
		.o_cycle(o_cycle), .o_instret(o_instret)
	);

	idu #(.XLEN(XLEN)) u_idu (
		.i_inst(inst), .o_opcode(opcode), .o_funct3(funct3), .o_inst30(inst30),
		.o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm)
	);

	regfile #(.XLEN(XLEN)) u_rf (
		.clk(clk), .i_rst(i_rst), .i_we(reg_we), .i_rd(rd), .i_wdata(rd_data),
		.i_rs1(rs1), .i_rs2(rs2), .o_src1(src1), .o_src2(src2)
	);

	exu #(.XLEN(XLEN)) u_exu (
		.i_opcode(opcode), .i_funct3(funct3), .i_inst30(inst30),
		.i_src1(src1), .i_src2(src2), .i_imm(imm), .i_pc(pc), .i_rdata(i_dmem_rdata),
		.o_rd_wen(rd_wen), .o_rd_data(rd_data), .o_mem_r(mem_r), .o_mem_w(mem_w),
		.o_mem_addr(o_dmem_addr), .o_wdata(o_dmem_wdata), .o_dnpc(dnpc)
	);

endmodule

`default_nettype wire

// ==== source/core_ctrl.sv ====
// Instruction sequencing FSM
`timescale 1ns/1ns
`default_nettype none

module core_ctrl import rv_pkg::*; #(
	parameter int XLEN = XLEN_DEF
) (
	input  logic            clk,
	input  logic            i_rst,
	input  logic [31:0]     i_imem_rdata,
	input  logic            i_mem_r,
	input  logic            i_mem_w,
	input  logic            i_rd_wen,
	input  logic [XLEN-1:0] i_dnpc,
	output logic [XLEN-1:0] o_imem_addr,
	output logic [31:0]     o_inst,
	output logic [XLEN-1:0] o_pc,
	output logic            o_dmem_r,
	output logic            o_dmem_w,
	output logic            o_reg_we,
	output logic            o_retire
);
	ctrl_state_t     state, state_nxt;
	logic [XLEN-1:0] pc;
	logic [31:0]     ir; // instruction register

	always_comb begin
		case (state)
			FETCH:   state_nxt = DECODE;
			DECODE:  state_nxt = EXEC;
			EXEC:    state_nxt = (i_mem_r || i_mem_w) ? MEM : WB;
			MEM:     state_nxt = WB;
			WB:      state_nxt = FETCH;
			default: state_nxt = FETCH;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= FETCH;
			pc    <= '0;
		end else begin
			state <= state_nxt;
			if (state == WB)
				pc <= i_dnpc; // branch target or pc+4
		end
	end

	// imem answers one cycle after fetch
	always_ff @(posedge clk) begin
		if (state == DECODE)
			ir <= i_imem_rdata;
	end

	assign o_imem_addr = pc;
	assign o_inst      = ir;
	assign o_pc        = pc;

	// each strobe lives for exactly one state
	assign o_dmem_r = (state == MEM) && i_mem_r;
	assign o_dmem_w = (state == MEM) && i_mem_w;
	assign o_reg_we = (state == WB) && i_rd_wen;
	assign o_retire = (state == WB);

endmodule

`default_nettype wire

// ==== source/perf_counter.sv ====
// Cycle and retire counters
`timescale 1ns/1ns
`default_nettype none

module perf_counter import rv_pkg::*; #(
	parameter int CNT_W = CNT_W_DEF
) (
	input  logic             clk,
	input  logic             i_rst,
	input  logic             i_retire,
	output logic [CNT_W-1:0] o_cycle,
	output logic [CNT_W-1:0] o_instret
);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_cycle   <= '0;
			o_instret <= '0;
		end else begin
			o_cycle <= o_cycle + 1'b1; // wraps freely
			if (i_retire)
				o_instret <= o_instret + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/idu.sv ====
// Instruction decode unit
`timescale 1ns/1ns
`default_nettype none

module idu import rv_pkg::*; #(
	parameter int XLEN = XLEN_DEF
) (
	input  logic [31:0]     i_inst,
	output logic [6:0]      o_opcode,
	output logic [2:0]      o_funct3,
	output logic            o_inst30,
	output logic [4:0]      o_rs1,
	output logic [4:0]      o_rs2,
	output logic [4:0]      o_rd,
	output logic [XLEN-1:0] o_imm
);
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign o_opcode = i_inst[6:0];
	assign o_rd     = i_inst[11:7];
	assign o_funct3 = i_inst[14:12];
	assign o_rs1    = i_inst[19:15];
	assign o_rs2    = i_inst[24:20];
	assign o_inst30 = i_inst[30]; // sub/sra select

	// sign always comes from bit 31
	assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
		i_inst[30:25], i_inst[11:8], 1'b0};
	assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
	assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
		i_inst[20], i_inst[30:21], 1'b0};

	always_comb begin
		case (o_opcode)
			OPC_LOAD, OPC_JALR,
			OPC_OP_IMM, OPC_OP_IMM_32: o_imm = imm_i;
			OPC_STORE:                 o_imm = imm_s;
			OPC_BRANCH:                o_imm = imm_b;
			OPC_LUI, OPC_AUIPC:        o_imm = imm_u;
			OPC_JAL:                   o_imm = imm_j;
			default:                   o_imm = '0; // OP has no immediate
		endcase
	end

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
// Integer register file
`timescale 1ns/1ns
`default_nettype none

module regfile import rv_pkg::*; #(
	parameter int XLEN = XLEN_DEF
) (
	input  logic            clk,
	input  logic            i_rst,
	input  logic            i_we,
	input  logic [4:0]      i_rd,
	input  logic [XLEN-1:0] i_wdata,
	input  logic [4:0]      i_rs1,
	input  logic [4:0]      i_rs2,
	output logic [XLEN-1:0] o_src1,
	output logic [XLEN-1:0] o_src2
);
	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (i_we && i_rd != 5'd0) begin
			regs[i_rd] <= i_wdata;
		end
	end

	// x0 hardwired
	assign o_src1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
	assign o_src2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// ==== source/exu.sv ====
// Execution unit
`timescale 1ns/1ns
`default_nettype none

module exu import rv_pkg::*; #(
	parameter int XLEN = XLEN_DEF
) (
	input  logic [6:0]      i_opcode,
	input  logic [2:0]      i_funct3,
	input  logic            i_inst30,
	input  logic [XLEN-1:0] i_src1,
	input  logic [XLEN-1:0] i_src2,
	input  logic [XLEN-1:0] i_imm,
	input  logic [XLEN-1:0] i_pc,
	input  logic [XLEN-1:0] i_rdata, // load data
	output logic            o_rd_wen,
	output logic [XLEN-1:0] o_rd_data,
	output logic            o_mem_r,
	output logic            o_mem_w,
	output logic [XLEN-1:0] o_mem_addr,
	output logic [XLEN-1:0] o_wdata, // store data
	output logic [XLEN-1:0] o_dnpc
);
	alu_sel_t        alu_sel;
	logic [XLEN-1:0] alu_a, alu_b, alu_result;
	logic            alu_sub_sra, alu_word;
	logic            alu_equal, alu_smaller, alu_borrow;
	logic            is_shift, br_take;
	logic [XLEN-1:0] npc_base, npc_offs, npc_sum, ld_data;

	assign is_shift = (i_funct3 == F3_SLL) || (i_funct3 == F3_SR);

	always_comb begin
		alu_sel     = SEL_AOS;
		alu_a       = i_src1;
		alu_b       = i_imm;
		alu_sub_sra = 1'b0;
		alu_word    = 1'b0;
		o_rd_wen    = 1'b1;
		case (i_opcode)
			OPC_LUI:   alu_a = '0; // 0 + imm
			OPC_AUIPC: alu_a = i_pc;
			OPC_JAL, OPC_JALR: begin
				alu_a = i_pc; // link value
				alu_b = XLEN'(4);
			end
			OPC_BRANCH: begin
				alu_b       = i_src2;
				alu_sub_sra = 1'b1;
				o_rd_wen    = 1'b0;
			end
			OPC_LOAD:  alu_b = i_imm; // rs1 + offset
			OPC_STORE: o_rd_wen = 1'b0;
			OPC_OP_IMM: begin
				alu_sel     = alu_sel_t'(i_funct3);
				alu_b       = is_shift ? {{(XLEN-6){1'b0}}, i_imm[5:0]} : i_imm;
				alu_sub_sra = (i_funct3 == F3_SR) && i_inst30;
			end
			OPC_OP: begin
				alu_sel     = alu_sel_t'(i_funct3);
				alu_b       = is_shift ? {{(XLEN-6){1'b0}}, i_src2[5:0]} : i_src2;
				alu_sub_sra = i_inst30;
			end
			OPC_OP_IMM_32: begin
				alu_sel     = alu_sel_t'(i_funct3);
				alu_b       = is_shift ? {{(XLEN-5){1'b0}}, i_imm[4:0]} : i_imm;
				alu_sub_sra = (i_funct3 == F3_SR) && i_inst30;
				alu_word    = 1'b1;
			end
			OPC_OP_32: begin
				alu_sel     = alu_sel_t'(i_funct3);
				alu_b       = is_shift ? {{(XLEN-5){1'b0}}, i_src2[4:0]} : i_src2;
				alu_sub_sra = i_inst30;
				alu_word    = 1'b1;
			end
			default: o_rd_wen = 1'b0; // fence, system: no-op
		endcase
	end

	alu #(.XLEN(XLEN)) u_alu (
		.i_sel(alu_sel), .i_a(alu_a), .i_b(alu_b),
		.i_sub_sra(alu_sub_sra), .i_word(alu_word),
		.o_result(alu_result), .o_equal(alu_equal),
		.o_smaller(alu_smaller), .o_borrow(alu_borrow)
	);

	always_comb begin
		case (i_funct3)
			F3_BEQ:  br_take = alu_equal;
			F3_BNE:  br_take = !alu_equal;
			F3_BLT:  br_take = alu_smaller;
			F3_BGE:  br_take = !alu_smaller;
			F3_BLTU: br_take = alu_borrow;
			F3_BGEU: br_take = !alu_borrow;
			default: br_take = 1'b0;
		endcase
	end

	// next pc
	assign npc_base = (i_opcode == OPC_JALR) ? i_src1 : i_pc;
	always_comb begin
		if (i_opcode == OPC_JAL || i_opcode == OPC_JALR)
			npc_offs = i_imm;
		else if (i_opcode == OPC_BRANCH && br_take)
			npc_offs = i_imm;
		else
			npc_offs = XLEN'(4);
	end
	assign npc_sum = npc_base + npc_offs;
	assign o_dnpc  = (i_opcode == OPC_JALR) ? {npc_sum[XLEN-1:1], 1'b0} : npc_sum;

	assign o_mem_r    = (i_opcode == OPC_LOAD);
	assign o_mem_w    = (i_opcode == OPC_STORE);
	assign o_mem_addr = (o_mem_r || o_mem_w) ? alu_result : '0;
	assign o_wdata    = o_mem_w ? i_src2 : '0; // full register, no strobes

	// bytes taken from the low end
	always_comb begin
		case (i_funct3)
			F3_LB:   ld_data = {{(XLEN-8){i_rdata[7]}}, i_rdata[7:0]};
			F3_LH:   ld_data = {{(XLEN-16){i_rdata[15]}}, i_rdata[15:0]};
			F3_LW:   ld_data = {{(XLEN-32){i_rdata[31]}}, i_rdata[31:0]};
			F3_LBU:  ld_data = {{(XLEN-8){1'b0}}, i_rdata[7:0]};
			F3_LHU:  ld_data = {{(XLEN-16){1'b0}}, i_rdata[15:0]};
			F3_LWU:  ld_data = {{(XLEN-32){1'b0}}, i_rdata[31:0]};
			F3_LD:   ld_data = i_rdata;
			default: ld_data = '0;
		endcase
	end

	assign o_rd_data = (i_opcode == OPC_LOAD) ? ld_data : alu_result;

endmodule

`default_nettype wire

// ==== source/alu.sv ====
// Integer ALU
`timescale 1ns/1ns
`default_nettype none

module alu import rv_pkg::*; #(
	parameter int XLEN = XLEN_DEF
) (
	input  alu_sel_t        i_sel,
	input  logic [XLEN-1:0] i_a,
	input  logic [XLEN-1:0] i_b,
	input  logic            i_sub_sra,
	input  logic            i_word, // 32-bit form
	output logic [XLEN-1:0] o_result,
	output logic            o_equal,
	output logic            o_smaller,
	output logic            o_borrow
);
	localparam int SHW = $clog2(XLEN);

	logic [XLEN-1:0] sum, sra_res, full_res;
	logic [31:0]     sraw_res, word_res;
	logic            lt, ltu;

	assign sum      = i_sub_sra ? i_a - i_b : i_a + i_b;
	assign sra_res  = $signed(i_a) >>> i_b[SHW-1:0];
	assign sraw_res = $signed(i_a[31:0]) >>> i_b[4:0];

	assign lt  = $signed(i_a) < $signed(i_b);
	assign ltu = i_a < i_b; // borrow of a - b

	always_comb begin
		case (i_sel)
			SEL_AOS:  full_res = sum;
			SEL_SLL:  full_res = i_a << i_b[SHW-1:0];
			SEL_SLT:  full_res = {{(XLEN-1){1'b0}}, lt};
			SEL_SLTU: full_res = {{(XLEN-1){1'b0}}, ltu};
			SEL_XOR:  full_res = i_a ^ i_b;
			SEL_SR:   full_res = i_sub_sra ? sra_res : i_a >> i_b[SHW-1:0];
			SEL_OR:   full_res = i_a | i_b;
			SEL_AND:  full_res = i_a & i_b;
			default:  full_res = sum;
		endcase
	end

	// word forms only exist for add/sub and shifts
	always_comb begin
		case (i_sel)
			SEL_SLL: word_res = i_a[31:0] << i_b[4:0];
			SEL_SR:  word_res = i_sub_sra ? sraw_res : i_a[31:0] >> i_b[4:0];
			default: word_res = sum[31:0];
		endcase
	end

	assign o_result  = i_word ? {{(XLEN-32){word_res[31]}}, word_res} : full_res;
	assign o_equal   = (i_a == i_b);
	assign o_smaller = lt;
	assign o_borrow  = ltu;

endmodule

`default_nettype wire

// ==== source/rv_pkg.sv ====
// RV64I core definitions
`default_nettype none

package rv_pkg;

	localparam int XLEN_DEF  = 64;
	localparam int CNT_W_DEF = 32; // perf counter width

	// major opcodes
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
	localparam logic [6:0] OPC_JAL       = 7'b1101111;
	localparam logic [6:0] OPC_JALR      = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
	localparam logic [6:0] OPC_LOAD      = 7'b0000011;
	localparam logic [6:0] OPC_STORE     = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;

	// branch funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// load funct3
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LD  = 3'b011;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_LWU = 3'b110;

	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SR  = 3'b101; // srl and sra share it

	// alu operation, same coding as funct3 of OP/OP_IMM
	typedef enum logic [2:0] {
		SEL_AOS  = 3'b000, // add or sub, also address calc
		SEL_SLL  = 3'b001,
		SEL_SLT  = 3'b010,
		SEL_SLTU = 3'b011,
		SEL_XOR  = 3'b100,
		SEL_SR   = 3'b101,
		SEL_OR   = 3'b110,
		SEL_AND  = 3'b111
	} alu_sel_t;

	typedef enum logic [2:0] {
		FETCH  = 3'd0,
		DECODE = 3'd1,
		EXEC   = 3'd2,
		MEM    = 3'd3,
		WB     = 3'd4
	} ctrl_state_t;

endpackage

`default_nettype wire
